// ==== Bender.yml ====
package:
  name: lcd_top

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lcd_bus_pkg.sv
      - hdl/lcd_ctrl_pkg.sv
      - hdl/text_writer.sv
      - hdl/word_fifo.sv
      - hdl/lcd_driver.sv
      - hdl/lcd_top.sv
  - target: test
    include_dirs:
      - hdl
      - test
    files:
      - test/lcd_top_tb.sv

// ==== hdl/lcd_bus_pkg.sv ====
package lcd_bus_pkg;

	// one byte on the LCD data lines
	typedef logic [7:0] lcd_byte_t;

	// word queued for the display: register select, read/write, byte
	typedef struct packed {
		logic      rs; // 0 command, 1 character data
		logic      rw; // 0 write
		lcd_byte_t data;
	} lcd_word_t;

	// what the driver puts on the pins
	typedef struct packed {
		logic      e; // enable strobe
		logic      rs;
		logic      rw;
		lcd_byte_t data;
	} lcd_pins_t;

	// fixed HD44780 command bytes
	localparam lcd_byte_t LCD_CMD_CLEAR = 8'h01;
	localparam lcd_byte_t LCD_CMD_WAKE  = 8'h30;
	localparam lcd_byte_t LCD_ADDR_LINE0 = 8'h80; // DDRAM address 0x00
	localparam lcd_byte_t LCD_ADDR_LINE1 = 8'hC0; // DDRAM address 0x40

endpackage

// ==== hdl/lcd_cfg.svh ====
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

// clock cycles per microsecond, every delay below is scaled by it
`define LCD_CYC_PER_US 1

// driver delay counter, sized for the whole power-up wait
`define LCD_CNT_BITS 10

// init timing in microseconds
`define LCD_T_POWERUP 500 // wait after reset
`define LCD_T_CMD 10 // e high per init command
`define LCD_T_INIT_END 440 // end of the config sequence

// per-word strobe timing in microseconds, measured from pop
`define LCD_T_E_LO 1 // e rises here
`define LCD_T_E_HI 14 // e falls here
`define LCD_T_WORD 50 // strobe slot ends, back to idle

// buffering between writer and driver
`define LCD_FIFO_DEPTH 8

// display geometry, two lines of this many cells
`define LCD_COLS 16

`endif

// ==== hdl/lcd_ctrl_pkg.sv ====
package lcd_ctrl_pkg;

	// init flags, split across function set, display control and entry mode
	typedef struct packed {
		logic lines;   // function set N
		logic font;    // function set F
		logic display; // display control D
		logic cursor;  // display control C
		logic blink;   // display control B
		logic incr;    // entry mode I/D
		logic shift;   // entry mode S
	} lcd_init_t;

	// cursor column on one line
	typedef logic [3:0] col_t;

	// lcd_driver sequencing
	typedef enum logic [1:0] {
		POWER_UP,
		INIT,
		IDLE,
		STROBE
	} drv_state_t;

	// text_writer, EMIT_HELD pushes a character held behind its wrap address
	typedef enum logic {
		READY,
		EMIT_HELD
	} wr_state_t;

endpackage

// ==== hdl/lcd_driver.sv ====
`timescale 1ns/1ps

`include "lcd_cfg.svh"

module lcd_driver (
	input  logic                    clk,
	input  logic                    rst_n,
	input  lcd_ctrl_pkg::lcd_init_t init_flags,
	input  lcd_bus_pkg::lcd_word_t  head_word,
	input  logic                    empty,
	output logic                    pop,
	output lcd_bus_pkg::lcd_pins_t  pins,
	output logic                    busy
);
	import lcd_bus_pkg::*;
	import lcd_ctrl_pkg::*;

	localparam int C = `LCD_CYC_PER_US;

	// init slots in microseconds from the start of INIT
	localparam int SLOT_WAKE  = 0; // 0x30 wake-up
	localparam int SLOT_FUNC  = 2 * `LCD_T_CMD; // config timeline starts here
	localparam int SLOT_DISP  = SLOT_FUNC + 60;
	localparam int SLOT_CLR   = SLOT_FUNC + 120;
	localparam int SLOT_ENTRY = SLOT_FUNC + 330;
	localparam int SLOT_END   = SLOT_FUNC + `LCD_T_INIT_END;

	// cycle counts
	localparam int T_PU   = `LCD_T_POWERUP * C;
	localparam int T_INIT = SLOT_END * C;
	localparam int T_E_LO = `LCD_T_E_LO * C;
	localparam int T_E_HI = `LCD_T_E_HI * C;
	localparam int T_WORD = `LCD_T_WORD * C;

	typedef logic [`LCD_CNT_BITS-1:0] cnt_t;

	drv_state_t state;
	cnt_t       cnt;
	lcd_word_t  cur_word; // popped word, held on the pins

	// e window of one init command
	function automatic logic in_slot(input cnt_t c, input int start_us);
		return (int'(c) >= start_us * C) && (int'(c) < (start_us + `LCD_T_CMD) * C);
	endfunction

	assign busy = (state != IDLE);
	assign pop  = (state == IDLE) && !empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= POWER_UP;
			cnt   <= '0;
		end else begin
			case (state)
				POWER_UP: begin
					if (cnt == cnt_t'(T_PU - 1)) begin
						state <= INIT;
						cnt   <= '0;
					end else begin
						cnt <= cnt + cnt_t'(1);
					end
				end
				INIT: begin
					if (cnt == cnt_t'(T_INIT - 1)) begin
						state <= IDLE;
						cnt   <= '0;
					end else begin
						cnt <= cnt + cnt_t'(1);
					end
				end
				IDLE: begin
					cnt <= '0;
					if (!empty)
						state <= STROBE; // head taken this cycle
				end
				STROBE: begin
					if (cnt == cnt_t'(T_WORD - 1)) begin
						state <= IDLE;
						cnt   <= '0;
					end else begin
						cnt <= cnt + cnt_t'(1);
					end
				end
				default: begin
					state <= POWER_UP;
					cnt   <= '0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop)
			cur_word <= head_word;
	end

	// pin values follow state and counter
	always_comb begin
		pins = '0;
		case (state)
			INIT: begin
				if (in_slot(cnt, SLOT_WAKE)) begin
					pins.e    = 1'b1;
					pins.data = LCD_CMD_WAKE;
				end else if (in_slot(cnt, SLOT_FUNC)) begin
					pins.e    = 1'b1;
					pins.data = {4'b0011, init_flags.lines, init_flags.font, 2'b00};
				end else if (in_slot(cnt, SLOT_DISP)) begin
					pins.e    = 1'b1;
					pins.data = {5'b00001, init_flags.display, init_flags.cursor,
						init_flags.blink};
				end else if (in_slot(cnt, SLOT_CLR)) begin
					pins.e    = 1'b1;
					pins.data = LCD_CMD_CLEAR;
				end else if (in_slot(cnt, SLOT_ENTRY)) begin
					pins.e    = 1'b1;
					pins.data = {6'b000001, init_flags.incr, init_flags.shift};
				end
			end
			STROBE: begin
				pins.rs   = cur_word.rs; // held for the whole slot
				pins.rw   = cur_word.rw;
				pins.data = cur_word.data;
				pins.e    = (int'(cnt) >= T_E_LO) && (int'(cnt) < T_E_HI);
			end
			default: pins = '0;
		endcase
	end

	a_e_state: assert property (@(posedge clk) disable iff (!rst_n)
		pins.e |-> state inside {INIT, STROBE});

	// busy drops only once init or a word slot has run its full length
	a_busy_idle: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> $past(state == INIT && cnt == cnt_t'(T_INIT - 1))
			|| $past(state == STROBE && cnt == cnt_t'(T_WORD - 1)));

	// a pop always starts a strobe slot
	a_pop_idle: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> state == IDLE ##1 state == STROBE);

endmodule

// ==== hdl/lcd_top.sv ====
`timescale 1ns/1ps

module lcd_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    char_valid,
	input  lcd_bus_pkg::lcd_byte_t  char_code,
	input  logic                    cmd_valid,
	input  lcd_bus_pkg::lcd_word_t  cmd_word,
	input  logic                    clear,
	input  lcd_ctrl_pkg::lcd_init_t init_flags,
	output lcd_bus_pkg::lcd_pins_t  pins,
	output logic                    busy,
	output logic                    wr_busy,
	output logic                    overflow
);
	import lcd_bus_pkg::*;

	logic      push;
	lcd_word_t push_word;
	logic      pop;
	lcd_word_t head_word;
	logic      empty;

	text_writer u_writer (
		.clk        (clk),
		.rst_n      (rst_n),
		.char_valid (char_valid),
		.char_code  (char_code),
		.cmd_valid  (cmd_valid),
		.cmd_word   (cmd_word),
		.clear      (clear),
		.push       (push),
		.push_word  (push_word),
		.wr_busy    (wr_busy)
	);

	word_fifo u_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (push),
		.push_word (push_word),
		.pop       (pop),
		.head_word (head_word),
		.empty     (empty),
		.full      (), // overflow covers the external view
		.overflow  (overflow)
	);

	lcd_driver u_driver (
		.clk        (clk),
		.rst_n      (rst_n),
		.init_flags (init_flags),
		.head_word  (head_word),
		.empty      (empty),
		.pop        (pop),
		.pins       (pins),
		.busy       (busy)
	);

endmodule

// ==== hdl/text_writer.sv ====
`timescale 1ns/1ps

`include "lcd_cfg.svh"

module text_writer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    char_valid,
	input  lcd_bus_pkg::lcd_byte_t  char_code,
	input  logic                    cmd_valid,
	input  lcd_bus_pkg::lcd_word_t  cmd_word,
	input  logic                    clear,
	output logic                    push,
	output lcd_bus_pkg::lcd_word_t  push_word,
	output logic                    wr_busy
);
	import lcd_bus_pkg::*;
	import lcd_ctrl_pkg::*;

	wr_state_t state;
	col_t      col;
	logic      line;      // 0 top, 1 bottom
	logic      wrap_pend; // last cell written, next char moves line
	lcd_byte_t held_char;
	lcd_word_t next_word;
	logic      accept;

	assign accept  = (state == READY) && (clear || cmd_valid || char_valid);
	assign wr_busy = (state == EMIT_HELD);

	// word for the next push, priority clear > cmd > char
	always_comb begin
		if (state == EMIT_HELD)
			next_word = '{rs: 1'b1, rw: 1'b0, data: held_char};
		else if (clear)
			next_word = '{rs: 1'b0, rw: 1'b0, data: LCD_CMD_CLEAR};
		else if (cmd_valid)
			next_word = cmd_word; // raw command, untouched
		else if (wrap_pend)
			next_word = '{rs: 1'b0, rw: 1'b0, data: line ? LCD_ADDR_LINE0 : LCD_ADDR_LINE1};
		else
			next_word = '{rs: 1'b1, rw: 1'b0, data: char_code};
	end

	always_ff @(posedge clk) begin
		push_word <= next_word;
		if (accept && char_valid)
			held_char <= char_code;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= READY;
			col       <= '0;
			line      <= 1'b0;
			wrap_pend <= 1'b0;
			push      <= 1'b0;
		end else begin
			push <= accept || (state == EMIT_HELD);
			if (state == EMIT_HELD) begin
				state <= READY;
				col   <= col + col_t'(1); // held char sits in cell 0
			end else if (clear) begin
				col       <= '0;
				line      <= 1'b0;
				wrap_pend <= 1'b0;
			end else if (cmd_valid) begin
				state <= READY; // cursor untouched
			end else if (char_valid) begin
				if (wrap_pend) begin
					state     <= EMIT_HELD;
					line      <= ~line;
					wrap_pend <= 1'b0;
					col       <= '0;
				end else if (col == col_t'(`LCD_COLS - 1)) begin
					col       <= '0;
					wrap_pend <= 1'b1;
				end else begin
					col <= col + col_t'(1);
				end
			end
		end
	end

	// a push out of READY answers a strobe of the cycle before
	a_push_cause: assert property (@(posedge clk) disable iff (!rst_n)
		(push && $past(state) == READY) |-> $past(clear || cmd_valid || char_valid));

endmodule

// ==== hdl/word_fifo.sv ====
`timescale 1ns/1ps

`include "lcd_cfg.svh"

module word_fifo (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    push,
	input  lcd_bus_pkg::lcd_word_t  push_word,
	input  logic                    pop,
	output lcd_bus_pkg::lcd_word_t  head_word,
	output logic                    empty,
	output logic                    full,
	output logic                    overflow
);
	import lcd_bus_pkg::*;

	localparam int DEPTH = `LCD_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] cnt_t;

	lcd_word_t mem [DEPTH];
	ptr_t      wr_ptr;
	ptr_t      rd_ptr;
	cnt_t      count;
	logic      wr_en;
	logic      rd_en;

	// circular increment, depth need not be a power of two
	function automatic ptr_t ptr_inc(input ptr_t p);
		return (p == ptr_t'(DEPTH - 1)) ? '0 : p + ptr_t'(1);
	endfunction

	assign empty     = (count == '0);
	assign full      = (count == cnt_t'(DEPTH));
	assign rd_en     = pop && !empty;
	assign wr_en     = push && (!full || rd_en); // full but popping still takes it
	assign head_word = mem[rd_ptr]; // fall-through head

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= push_word;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= ptr_inc(wr_ptr);
			if (rd_en)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({wr_en, rd_en})
				2'b10: count <= count + cnt_t'(1);
				2'b01: count <= count - cnt_t'(1);
				default: count <= count;
			endcase
			if (push && !wr_en)
				overflow <= 1'b1; // sticky, word dropped
		end
	end

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> !empty);

endmodule

// ==== lcd_top.f ====
+incdir+hdl
+incdir+test
hdl/lcd_bus_pkg.sv
hdl/lcd_ctrl_pkg.sv
hdl/text_writer.sv
hdl/word_fifo.sv
hdl/lcd_driver.sv
hdl/lcd_top.sv
test/lcd_top_tb.sv

// ==== test/lcd_tb_checks.svh ====
`ifndef LCD_TB_CHECKS_SVH
`define LCD_TB_CHECKS_SVH

lcd_word_t exp_q[$]; // expected words in display order
int        model_col  = 0;
bit        model_line = 1'b0; // 0 top, 1 bottom

task automatic check_word(input string what, input lcd_word_t exp, input lcd_word_t act);
	if (exp !== act) begin
		$display("** Error %s %s: expected %h actual %h", test_name, what, exp, act);
		error_count++;
	end
endtask

task automatic check_flag(input string what, input bit exp, input bit act);
	if (exp !== act) begin
		$display("** Error %s %s: expected %b actual %b", test_name, what, exp, act);
		error_count++;
	end
endtask

task automatic check_count(input string what, input int exp, input int act);
	if (exp != act) begin
		$display("** Error %s %s: expected %0d actual %0d", test_name, what, exp, act);
		error_count++;
	end
endtask

// a full line moves the cursor before the next character lands
task automatic model_char(input lcd_byte_t code);
	if (model_col == `LCD_COLS) begin
		exp_q.push_back(lcd_word_t'{1'b0, 1'b0, model_line ? 8'h80 : 8'hC0});
		model_line = ~model_line;
		model_col  = 0;
	end
	exp_q.push_back(lcd_word_t'{1'b1, 1'b0, code});
	model_col++;
endtask

task automatic model_clear();
	exp_q.push_back(lcd_word_t'{1'b0, 1'b0, 8'h01});
	model_col  = 0;
	model_line = 1'b0;
endtask

task automatic model_cmd(input lcd_word_t w);
	exp_q.push_back(w); // cursor untouched
endtask

task automatic compare_words();
	check_count("word count", exp_q.size(), mon_q.size());
	for (int i = checked; i < exp_q.size() && i < mon_q.size(); i++)
		check_word($sformatf("word %0d", i), exp_q[i], mon_q[i]);
	checked = exp_q.size();
endtask

`endif

// ==== test/lcd_top_tb.sv ====
`timescale 1ns/1ps

`include "lcd_cfg.svh"

module lcd_top_tb;
	import lcd_bus_pkg::*;
	import lcd_ctrl_pkg::*;

	localparam int C     = `LCD_CYC_PER_US;
	localparam int SLOT  = 50 * C + 4; // cost of one word
	localparam int WORDS = 8 + 36 + 22 + 12; // tests 2 to 5, quiet window included
	localparam int LIMIT = (WORDS * SLOT + 940 * C) * 5 / 4;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        char_valid;
	lcd_byte_t   char_code;
	logic        cmd_valid;
	lcd_word_t   cmd_word;
	logic        clear;
	lcd_init_t   init_flags;
	lcd_pins_t   pins;
	logic        busy;
	logic        wr_busy;
	logic        overflow;
	lcd_word_t   mon_q[$]; // word at each rising e
	int          rise_q[$]; // cycle of each rising e
	int          len_q[$]; // e high length per word
	int          mon_cyc = 0;
	int          e_run = 0;
	logic        e_prev = 1'b0;
	int          wr_busy_cycles = 0;
	int          checked = 0;
	int          error_count = 0;
	int          errors_before = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          timeout_cyc = 0;
	string       test_name;
	logic [31:0] lfsr = 32'he0;

	`include "lcd_tb_checks.svh"

	lcd_top dut (.*);

	always #5 clk = ~clk;

	// pins sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin
		mon_cyc++;
		if (wr_busy)
			wr_busy_cycles++;
		if (pins.e && !e_prev) begin
			mon_q.push_back(lcd_word_t'{pins.rs, pins.rw, pins.data});
			rise_q.push_back(mon_cyc);
			e_run = 0;
		end
		if (pins.e)
			e_run++;
		else if (e_prev)
			len_q.push_back(e_run);
		e_prev = pins.e;
	end

	always @(posedge clk) begin
		timeout_cyc++;
		if (timeout_cyc > LIMIT) begin
			$display("timeout: no end of run within %0d cycles", LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic send_char(input lcd_byte_t code);
		@(posedge clk);
		char_valid <= 1'b1;
		char_code  <= code;
		@(posedge clk);
		char_valid <= 1'b0;
		model_char(code);
	endtask

	task automatic send_cmd(input lcd_word_t w);
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd_word  <= w;
		@(posedge clk);
		cmd_valid <= 1'b0;
		model_cmd(w);
	endtask

	task automatic send_clear();
		@(posedge clk);
		clear <= 1'b1;
		@(posedge clk);
		clear <= 1'b0;
		model_clear();
	endtask

	// every expected word shown and the driver back in idle
	task automatic wait_drained();
		do
			@(posedge clk);
		while (mon_q.size() < exp_q.size() || busy);
	endtask

	task automatic start_test(input string name);
		test_name     = name;
		errors_before = error_count;
	endtask

	task automatic end_test();
		compare_words();
		tests_run++;
		if (error_count == errors_before) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, error_count - errors_before);
		end
	endtask

	task automatic test_init();
		bit early;
		early = 1'b0;
		start_test("init");
		model_cmd(lcd_word_t'{1'b0, 1'b0, 8'h30});
		model_cmd(lcd_word_t'{1'b0, 1'b0, {4'b0011, init_flags.lines, init_flags.font, 2'b00}});
		model_cmd(lcd_word_t'{1'b0, 1'b0,
			{5'b00001, init_flags.display, init_flags.cursor, init_flags.blink}});
		model_cmd(lcd_word_t'{1'b0, 1'b0, 8'h01});
		model_cmd(lcd_word_t'{1'b0, 1'b0, {6'b000001, init_flags.incr, init_flags.shift}});
		do begin
			@(posedge clk);
			if (!busy && mon_q.size() < 5)
				early = 1'b1;
		end while (mon_q.size() < 5 || busy);
		if (early) begin
			$display("test %s: busy fell before the fifth init command", test_name);
			error_count++;
		end
		for (int i = 0; i < 5 && i < len_q.size(); i++)
			check_count("init e high", `LCD_T_CMD * C, len_q[i]);
		end_test();
	endtask

	task automatic test_chars_cmds();
		int first;
		first = exp_q.size();
		start_test("chars_cmds");
		for (int i = 0; i < 6; i++) begin
			if (i == 3)
				send_cmd(lcd_word_t'(10'(random_bits(10))));
			send_char(lcd_byte_t'(random_bits(8)));
		end
		send_cmd(lcd_word_t'{1'b0, 1'b0, 8'h0C});
		wait_drained();
		for (int i = first; i < mon_q.size() && i < len_q.size(); i++) begin
			check_count("e high", 13 * C, len_q[i]);
			if (rise_q[i] - rise_q[i-1] < 50 * C + 1) begin
				$display("test %s: e rose again after only %0d cycles", test_name,
					rise_q[i] - rise_q[i-1]);
				error_count++;
			end
		end
		end_test();
	endtask

	task automatic test_wrap();
		int busy_seen;
		start_test("wrap");
		send_clear();
		wait_drained();
		busy_seen = wr_busy_cycles;
		for (int i = 1; i <= 33; i++) begin
			send_char(8'h40 + 8'(i));
			wait_drained(); // spaced, FIFO never fills
		end
		check_count("wr_busy cycles", 2, wr_busy_cycles - busy_seen);
		end_test();
	endtask

	task automatic test_clear();
		start_test("clear");
		for (int i = 0; i < 3; i++)
			send_char(lcd_byte_t'(random_bits(8)));
		send_clear();
		wait_drained();
		for (int i = 0; i < 17; i++) begin
			send_char(lcd_byte_t'(random_bits(8)));
			wait_drained();
		end
		end_test();
	endtask

	task automatic test_overflow();
		int        first;
		bit        busy_seen;
		lcd_byte_t code;
		busy_seen = 1'b0;
		start_test("overflow");
		send_clear();
		wait_drained();
		check_flag("overflow before burst", 1'b0, overflow);
		first = exp_q.size();
		for (int i = 0; i < `LCD_FIFO_DEPTH + 3; i++) begin
			code = lcd_byte_t'(random_bits(8));
			@(posedge clk);
			char_valid <= 1'b1;
			char_code  <= code;
			model_char(code);
		end
		@(posedge clk);
		char_valid <= 1'b0;
		// first word leaves at once, the FIFO keeps the next DEPTH
		while (exp_q.size() > first + `LCD_FIFO_DEPTH + 1)
			void'(exp_q.pop_back());
		wait_drained();
		check_flag("overflow after burst", 1'b1, overflow);
		repeat (2 * SLOT) begin
			@(posedge clk);
			if (busy)
				busy_seen = 1'b1;
		end
		check_count("words after drain", exp_q.size(), mon_q.size());
		check_flag("busy after drain", 1'b0, busy_seen);
		end_test();
	endtask

	initial begin
		rst_n      = 1'b0;
		char_valid = 1'b0;
		char_code  = '0;
		cmd_valid  = 1'b0;
		cmd_word   = '0;
		clear      = 1'b0;
		init_flags = lcd_init_t'(7'(random_bits(7)));
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		test_init();
		test_chars_cmds();
		test_wrap();
		test_clear();
		test_overflow();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
